//--- Bender.yml
package:
  name: atc

sources:
  - files:
      - source/atc_pkg.sv
      - source/atc_fifo.sv
      - source/aircraft_id_manager.sv
      - source/runway_manager.sv
      - source/request_fsm.sv
      - source/reply_sender.sv
      - source/atc_top.sv
  - target: test
    files:
      - tb/atc_assertions.sv
      - tb/atc_tb.sv

//--- build.f
source/atc_pkg.sv
source/atc_fifo.sv
source/aircraft_id_manager.sv
source/runway_manager.sv
source/request_fsm.sv
source/reply_sender.sv
source/atc_top.sv
tb/atc_assertions.sv
tb/atc_tb.sv

//--- source/aircraft_id_manager.sv
// Pool of sixteen plane IDs, one taken bit each
// free_id is the lowest free ID and is only meaningful while pool_full is low
// A release wins over a take in the same cycle

`timescale 1ns/1ns

module aircraft_id_manager import atc_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  plane_id_t release_plane,
  input  logic      release_id,
  input  logic      take_id,
  output plane_id_t free_id,
  output id_mask_t  taken,
  output logic      pool_full
);

  assign pool_full = &taken;

  // Priority search, lowest index wins
  always_comb begin
    free_id = '0;
    for (int i = NUM_IDS - 1; i >= 0; i--) begin
      if (!taken[i]) begin
        free_id = plane_id_t'(i);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      taken <= '0;
    end else if (release_id) begin
      taken[release_plane] <= 1'b0;
    end else if (take_id && !pool_full) begin
      taken[free_id] <= 1'b1;
    end
  end

endmodule

//--- source/atc_fifo.sv
// Circular buffer with an occupancy count and a registered read port
// data_out only updates on an accepted pop and holds its value otherwise
// DEPTH must be at least 2; push when full and pop when empty are dropped

`timescale 1ns/1ns

module atc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic [WIDTH-1:0] data_in,
  input  logic             push,
  input  logic             pop,
  output logic [WIDTH-1:0] data_out,
  output logic             full,
  output logic             empty
);

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       do_push;
  logic                       do_pop;

  assign empty   = (count == 0);
  assign full    = (count == DEPTH);
  assign do_pop  = pop && !empty;
  // A pop in the same cycle frees the slot that a full FIFO needs
  assign do_push = push && (!full || do_pop);

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= data_in;
    end
    if (do_pop) begin
      data_out <= mem[rd_ptr];
    end
  end

endmodule

//--- source/atc_pkg.sv
// Shared types and constants for the message-level airport traffic controller
// A message is 9 bits made of plane ID, type and action, with the ID in the top bits
// Sixteen plane IDs, two runways, every FIFO four entries deep

package atc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_IDS     = 16;
  localparam int NUM_RUNWAYS = 2;
  localparam int QUEUE_DEPTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Message fields
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0] plane_id_t;

  // Request: bit 1 is landing. Declare: bit 0 is runway.
  // Clear reply: bit 1 is landing, bit 0 is runway
  typedef logic [1:0] msg_action_t;

  typedef enum logic [2:0] {
    REQUEST   = 3'd0,
    DECLARE   = 3'd1,
    EMERGENCY = 3'd2,
    ID_PLEASE = 3'd3,
    CLEAR     = 3'd4,
    HOLD      = 3'd5,
    SAY_AGAIN = 3'd6,
    DIVERT    = 3'd7
  } msg_type_t;

  typedef struct packed {
    plane_id_t   plane_id;
    msg_type_t   msg_type;
    msg_action_t msg_action;
  } msg_t;

  // Action sent with plane ID 0 when no ID is left
  localparam msg_action_t ID_FULL_ACTION = 2'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Runway and ID bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    plane_id_t plane_id;
    logic      active;
  } runway_t;

  typedef logic [NUM_RUNWAYS-1:0] runway_status_t;
  typedef logic [NUM_IDS-1:0]     id_mask_t;

endpackage

//--- source/atc_top.sv
// Top level of the traffic controller, message in and reply out as strobes
// A message arriving while the request FIFO is full is dropped
// reply_ready is a level; replies wait in the reply FIFO while it is low

`timescale 1ns/1ns

module atc_top import atc_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  msg_t           msg_in,
  input  logic           msg_valid,
  output msg_t           reply_out,
  output logic           reply_valid,
  input  logic           reply_ready,
  output runway_status_t runway_active
);

  msg_t      request;
  logic      request_pop;
  logic      request_empty;
  plane_id_t takeoff_head;
  plane_id_t landing_head;
  logic      takeoff_push;
  logic      takeoff_pop;
  logic      takeoff_full;
  logic      takeoff_empty;
  logic      landing_push;
  logic      landing_pop;
  logic      landing_full;
  logic      landing_empty;
  plane_id_t free_id;
  id_mask_t  taken;
  logic      pool_full;
  logic      take_id;
  logic      release_id;
  logic      lock;
  logic      unlock;
  logic      runway_sel;
  plane_id_t lock_plane;
  msg_t      reply;
  logic      reply_push;
  logic      reply_full;

  ////////////////////////////////////////////////////////////////////////////
  // Request FIFO and aircraft queues
  ////////////////////////////////////////////////////////////////////////////

  atc_fifo #(.WIDTH($bits(msg_t)), .DEPTH(QUEUE_DEPTH)) u_request_fifo (
    .clock (clock), .reset (reset), .data_in (msg_in), .push (msg_valid),
    .pop (request_pop), .data_out (request), .full (), .empty (request_empty)
  );

  atc_fifo #(.WIDTH($bits(plane_id_t)), .DEPTH(QUEUE_DEPTH)) u_takeoff_fifo (
    .clock (clock), .reset (reset), .data_in (request.plane_id),
    .push (takeoff_push), .pop (takeoff_pop), .data_out (takeoff_head),
    .full (takeoff_full), .empty (takeoff_empty)
  );

  atc_fifo #(.WIDTH($bits(plane_id_t)), .DEPTH(QUEUE_DEPTH)) u_landing_fifo (
    .clock (clock), .reset (reset), .data_in (request.plane_id),
    .push (landing_push), .pop (landing_pop), .data_out (landing_head),
    .full (landing_full), .empty (landing_empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Bookkeeping, control and replies
  ////////////////////////////////////////////////////////////////////////////

  aircraft_id_manager u_id_manager (
    .clock (clock), .reset (reset), .release_plane (request.plane_id),
    .release_id (release_id), .take_id (take_id), .free_id (free_id),
    .taken (taken), .pool_full (pool_full)
  );

  // Unlocks always come from the plane that sent the declare
  runway_manager u_runway_manager (
    .clock (clock), .reset (reset), .lock_plane (lock_plane),
    .unlock_plane (request.plane_id), .runway_sel (runway_sel), .lock (lock),
    .unlock (unlock), .runway_active (runway_active)
  );

  request_fsm u_request_fsm (.*);

  reply_sender u_reply_sender (
    .clock (clock), .reset (reset), .reply (reply), .reply_push (reply_push),
    .reply_ready (reply_ready), .reply_full (reply_full), .reply_out (reply_out),
    .reply_valid (reply_valid)
  );

endmodule

//--- source/reply_sender.sv
// Reply FIFO and output sequencer
// reply_valid is a one-cycle strobe, one cycle after the pop
// Pops at most every second cycle, and only while reply_ready is high

`timescale 1ns/1ns

module reply_sender import atc_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  msg_t reply,
  input  logic reply_push,
  input  logic reply_ready,
  output logic reply_full,
  output msg_t reply_out,
  output logic reply_valid
);

  typedef enum logic {
    WAIT,
    SEND
  } state_t;

  state_t state;
  logic   reply_empty;
  logic   reply_pop;

  atc_fifo #(
    .WIDTH($bits(msg_t)),
    .DEPTH(QUEUE_DEPTH)
  ) u_reply_fifo (
    .clock    (clock),
    .reset    (reset),
    .data_in  (reply),
    .push     (reply_push),
    .pop      (reply_pop),
    .data_out (reply_out),
    .full     (reply_full),
    .empty    (reply_empty)
  );

  assign reply_pop   = (state == WAIT) && !reply_empty && reply_ready;
  assign reply_valid = (state == SEND);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= WAIT;
    end else begin
      case (state)
        WAIT:    state <= reply_pop ? SEND : WAIT;
        default: state <= WAIT;
      endcase
    end
  end

endmodule

//--- source/request_fsm.sv
// Request interpreter and clearance scheduler
// Handles one request at a time; the request is valid in INTERPRET after the pop
// Queue heads are valid in CLR_TAKEOFF and CLR_LANDING, one cycle after their pop
// Holds in REPLY and QUEUE_CLR while the reply FIFO is full

`timescale 1ns/1ns

module request_fsm import atc_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  msg_t           request,
  input  logic           request_empty,
  input  plane_id_t      takeoff_head,
  input  plane_id_t      landing_head,
  input  logic           takeoff_full,
  input  logic           takeoff_empty,
  input  logic           landing_full,
  input  logic           landing_empty,
  input  logic           reply_full,
  input  runway_status_t runway_active,
  input  id_mask_t       taken,
  input  plane_id_t      free_id,
  input  logic           pool_full,
  output logic           request_pop,
  output logic           takeoff_push,
  output logic           landing_push,
  output logic           takeoff_pop,
  output logic           landing_pop,
  output logic           take_id,
  output logic           release_id,
  output logic           lock,
  output logic           unlock,
  output logic           runway_sel,
  output plane_id_t      lock_plane,
  output msg_t           reply,
  output logic           reply_push
);

  typedef enum logic [2:0] {
    QUIET,
    INTERPRET,
    REPLY,
    CHECK_QUEUES,
    CLR_TAKEOFF,
    CLR_LANDING,
    QUEUE_CLR
  } state_t;

  state_t state;
  state_t next_state;
  msg_t   next_reply;
  logic   load_reply;
  logic   takeoff_first;
  logic   can_clear;
  logic   pick_takeoff;
  logic   pick_landing;

  // Clear only with a free runway and no request waiting
  assign can_clear    = (runway_active != '1) && request_empty;
  assign pick_takeoff = can_clear && !takeoff_empty && (takeoff_first || landing_empty);
  assign pick_landing = can_clear && !landing_empty && !pick_takeoff;

  always_comb begin
    next_state   = state;
    next_reply   = reply;
    load_reply   = 1'b0;
    request_pop  = 1'b0;
    takeoff_push = 1'b0;
    landing_push = 1'b0;
    takeoff_pop  = 1'b0;
    landing_pop  = 1'b0;
    take_id      = 1'b0;
    release_id   = 1'b0;
    lock         = 1'b0;
    unlock       = 1'b0;
    runway_sel   = 1'b0;
    lock_plane   = takeoff_head;
    reply_push   = 1'b0;

    case (state)
      QUIET, CHECK_QUEUES: begin
        if (state == QUIET && !request_empty) begin
          request_pop = 1'b1;
          next_state  = INTERPRET;
        end else if (pick_takeoff) begin
          takeoff_pop = 1'b1;
          next_state  = CLR_TAKEOFF;
        end else if (pick_landing) begin
          landing_pop = 1'b1;
          next_state  = CLR_LANDING;
        end else begin
          next_state = QUIET;
        end
      end

      INTERPRET: begin
        next_state = CHECK_QUEUES;
        case (request.msg_type)
          REQUEST: begin
            // Unknown IDs get no answer
            if (taken[request.plane_id]) begin
              load_reply = 1'b1;
              next_state = REPLY;
              next_reply = '{request.plane_id, HOLD, 2'b00};
              if (request.msg_action[1]) begin
                if (landing_full) next_reply.msg_type = DIVERT;
                else landing_push = 1'b1;
              end else begin
                if (takeoff_full) next_reply.msg_type = DIVERT;
                else takeoff_push = 1'b1;
              end
            end
          end
          DECLARE: begin
            if (taken[request.plane_id]) begin
              release_id = 1'b1;
              unlock     = 1'b1;
              runway_sel = request.msg_action[0];
            end
          end
          ID_PLEASE: begin
            load_reply = 1'b1;
            next_state = REPLY;
            if (pool_full) begin
              next_reply = '{plane_id_t'(0), ID_PLEASE, ID_FULL_ACTION};
            end else begin
              take_id    = 1'b1;
              next_reply = '{free_id, ID_PLEASE, 2'b00};
            end
          end
          default: begin
            load_reply = 1'b1;
            next_state = REPLY;
            next_reply = '{request.plane_id, SAY_AGAIN, 2'b00};
          end
        endcase
      end

      REPLY: begin
        if (!reply_full) begin
          reply_push = 1'b1;
          next_state = CHECK_QUEUES;
        end
      end

      // Lowest free runway; one was free when the head was popped
      CLR_TAKEOFF, CLR_LANDING: begin
        lock       = 1'b1;
        runway_sel = runway_active[0];
        lock_plane = (state == CLR_TAKEOFF) ? takeoff_head : landing_head;
        load_reply = 1'b1;
        next_reply = '{lock_plane, CLEAR, {state == CLR_LANDING, runway_active[0]}};
        next_state = QUEUE_CLR;
      end

      QUEUE_CLR: begin
        if (!reply_full) begin
          reply_push = 1'b1;
          next_state = QUIET;
        end
      end

      default: next_state = QUIET;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= QUIET;
      takeoff_first <= 1'b1;
    end else begin
      state <= next_state;
      // Priority swaps after every clearance
      if (state == CLR_TAKEOFF || state == CLR_LANDING) begin
        takeoff_first <= ~takeoff_first;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load_reply) begin
      reply <= next_reply;
    end
  end

endmodule

//--- source/runway_manager.sv
// Lock registers for the runways, each owned by the plane ID that took it
// Only the owner can unlock; lock and unlock together are both ignored
// runway_active follows a lock or unlock pulse by one cycle

`timescale 1ns/1ns

module runway_manager import atc_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  plane_id_t      lock_plane,
  input  plane_id_t      unlock_plane,
  input  logic           runway_sel,
  input  logic           lock,
  input  logic           unlock,
  output runway_status_t runway_active
);

  runway_t runway [NUM_RUNWAYS];

  always_comb begin
    for (int r = 0; r < NUM_RUNWAYS; r++) begin
      runway_active[r] = runway[r].active;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < NUM_RUNWAYS; r++) begin
        runway[r] <= '0;
      end
    end else if (lock && !unlock) begin
      runway[runway_sel].plane_id <= lock_plane;
      runway[runway_sel].active   <= 1'b1;
    end else if (unlock && !lock) begin
      // Another aircraft naming this runway leaves it locked
      if (runway[runway_sel].plane_id == unlock_plane) begin
        runway[runway_sel].active <= 1'b0;
      end
    end
  end

endmodule

//--- tb/atc_assertions.sv
// Protocol checks on one-cycle pulses and on signals that reset clears
// Bound to the reply sender and to the runway manager
// The sender instance watches reply_valid and its FIFO push and pop
// The runway instance watches the lock pulse and runway_active

`timescale 1ns/1ns

module atc_assertions (
  input logic       clock,
  input logic       reset,
  input logic       strobe,
  input logic [1:0] status
);

  // Pulse lasts exactly one cycle
  strobe_one_cycle: assert property (
    @(posedge clock) disable iff (reset) strobe |=> !strobe
  ) else $error("strobe high for two cycles");

  strobe_low_after_reset: assert property (
    @(posedge clock) reset |=> !strobe
  ) else $error("strobe high after reset");

  status_clear_after_reset: assert property (
    @(posedge clock) reset |=> (status == '0)
  ) else $error("status not clear after reset");

endmodule

bind reply_sender atc_assertions u_reply_assertions (
  .clock  (clock),
  .reset  (reset),
  .strobe (reply_valid),
  .status ({reply_push, reply_pop})
);

bind runway_manager atc_assertions u_runway_assertions (
  .clock  (clock),
  .reset  (reset),
  .strobe (lock),
  .status (runway_active)
);

//--- tb/atc_tb.sv
// Table-driven testbench for the traffic controller, one message per row
// A row waits for its expected replies, then a quiet window catches extra ones
// reply_ready toggles from an LFSR for the rows from RANDOM_FROM on

`timescale 1ns/1ns

module atc_tb import atc_pkg::*; ();

  localparam int          NUM_ROWS      = 21;
  localparam int          RANDOM_FROM   = 14;
  localparam int          REPLY_TIMEOUT = 200;
  localparam int          QUIET_CYCLES  = 40;
  localparam logic [15:0] LFSR_SEED     = 16'd46625;
  localparam msg_t        NO_REPLY      = '0;

  typedef struct packed {
    msg_t           msg;
    logic [1:0]     count;
    msg_t           first;
    msg_t           second;
    runway_status_t runway;
  } row_t;

  logic           clock;
  logic           reset;
  msg_t           msg_in;
  logic           msg_valid;
  msg_t           reply_out;
  logic           reply_valid;
  logic           reply_ready;
  runway_status_t runway_active;

  row_t        rows [NUM_ROWS];
  msg_t        replies [$];
  logic [15:0] lfsr;
  logic        random_ready;
  int          errors;
  int          passed_rows;
  bit          timed_out;

  atc_top u_atc_top (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic msg_t make_msg(int id, msg_type_t kind, int action);
    msg_t m;
    m.plane_id   = plane_id_t'(id);
    m.msg_type   = kind;
    m.msg_action = msg_action_t'(action);
    return m;
  endfunction

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic check_value(string what, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("ERR %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
      errors++;
    end
  endtask

  task automatic send_msg(msg_t m);
    @(posedge clock);
    #5;
    msg_in    = m;
    msg_valid = 1'b1;
    @(posedge clock);
    #5;
    msg_valid = 1'b0;
  endtask

  task automatic wait_replies(int expected, output bit late);
    int cycles;
    late   = 1'b0;
    cycles = 0;
    while (replies.size() < expected && !late) begin
      @(posedge clock);
      cycles++;
      if (cycles >= REPLY_TIMEOUT) late = 1'b1;
    end
    // Any reply in this window beyond the expected count is a stray one
    repeat (QUIET_CYCLES) @(posedge clock);
  endtask

  task automatic run_row(int index);
    row_t row;
    int   errors_before;
    bit   late;
    row           = rows[index];
    errors_before = errors;
    replies.delete();
    random_ready  = (index >= RANDOM_FROM);
    send_msg(row.msg);
    wait_replies(row.count, late);
    if (late) begin
      $display("Row %0d timed out after %0d cycles with %0d of %0d replies",
               index, REPLY_TIMEOUT, replies.size(), row.count);
      timed_out = 1'b1;
    end
    check_value($sformatf("row %0d reply count", index), replies.size(), row.count);
    if (row.count > 0 && replies.size() > 0) begin
      check_value($sformatf("row %0d first reply", index), replies[0], row.first);
    end
    if (row.count > 1 && replies.size() > 1) begin
      check_value($sformatf("row %0d second reply", index), replies[1], row.second);
    end
    check_value($sformatf("row %0d runway_active", index), runway_active, row.runway);
    if (errors == errors_before && !late) begin
      passed_rows++;
      $display("Row %0d passed", index);
    end else begin
      $display("Row %0d failed", index);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, ready driver and reply capture
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    lfsr = LFSR_SEED;
    forever begin
      @(posedge clock);
      #5;
      if (random_ready) begin
        lfsr        = lfsr_step(lfsr);
        reply_ready = lfsr[0];
      end else begin
        reply_ready = 1'b1;
      end
    end
  end

  always @(negedge clock) begin
    if (!reset && reply_valid) begin
      replies.push_back(reply_out);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table and main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    msg_in       = '0;
    msg_valid    = 1'b0;
    reply_ready  = 1'b1;
    reset        = 1'b1;
    random_ready = 1'b0;
    errors       = 0;
    passed_rows  = 0;
    timed_out    = 1'b0;

    // Message, reply count, first reply, second reply, runway_active
    rows = '{
      '{make_msg(0, ID_PLEASE, 0), 2'd1, make_msg(0, ID_PLEASE, 0), NO_REPLY, 2'b00},
      '{make_msg(0, ID_PLEASE, 0), 2'd1, make_msg(1, ID_PLEASE, 0), NO_REPLY, 2'b00},
      '{make_msg(0, ID_PLEASE, 0), 2'd1, make_msg(2, ID_PLEASE, 0), NO_REPLY, 2'b00},
      '{make_msg(0, ID_PLEASE, 0), 2'd1, make_msg(3, ID_PLEASE, 0), NO_REPLY, 2'b00},
      '{make_msg(0, REQUEST, 0), 2'd2, make_msg(0, HOLD, 0), make_msg(0, CLEAR, 0), 2'b01},
      '{make_msg(1, REQUEST, 2), 2'd2, make_msg(1, HOLD, 0), make_msg(1, CLEAR, 3), 2'b11},
      '{make_msg(2, REQUEST, 0), 2'd1, make_msg(2, HOLD, 0), NO_REPLY, 2'b11},
      '{make_msg(3, DECLARE, 1), 2'd0, NO_REPLY, NO_REPLY, 2'b11},
      '{make_msg(0, DECLARE, 0), 2'd1, make_msg(2, CLEAR, 0), NO_REPLY, 2'b11},
      '{make_msg(1, EMERGENCY, 2), 2'd1, make_msg(1, SAY_AGAIN, 0), NO_REPLY, 2'b11},
      '{make_msg(2, HOLD, 1), 2'd1, make_msg(2, SAY_AGAIN, 0), NO_REPLY, 2'b11},
      '{make_msg(9, REQUEST, 0), 2'd0, NO_REPLY, NO_REPLY, 2'b11},
      '{make_msg(0, ID_PLEASE, 0), 2'd1, make_msg(0, ID_PLEASE, 0), NO_REPLY, 2'b11},
      '{make_msg(0, ID_PLEASE, 0), 2'd1, make_msg(3, ID_PLEASE, 0), NO_REPLY, 2'b11},
      '{make_msg(1, DECLARE, 1), 2'd0, NO_REPLY, NO_REPLY, 2'b01},
      '{make_msg(0, REQUEST, 2), 2'd2, make_msg(0, HOLD, 0), make_msg(0, CLEAR, 3), 2'b11},
      '{make_msg(3, REQUEST, 0), 2'd1, make_msg(3, HOLD, 0), NO_REPLY, 2'b11},
      '{make_msg(2, DECLARE, 0), 2'd1, make_msg(3, CLEAR, 0), NO_REPLY, 2'b11},
      '{make_msg(0, DECLARE, 1), 2'd0, NO_REPLY, NO_REPLY, 2'b01},
      '{make_msg(3, DECLARE, 0), 2'd0, NO_REPLY, NO_REPLY, 2'b00},
      '{make_msg(0, ID_PLEASE, 0), 2'd1, make_msg(0, ID_PLEASE, 0), NO_REPLY, 2'b00}
    };

    repeat (8) @(posedge clock);
    #5;
    reset = 1'b0;

    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      run_row(i);
    end

    $display("Rows passed %0d of %0d, errors %0d", passed_rows, NUM_ROWS, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
